/* Bender.yml */
package:
  name: wb_stage

sources:
  - wb_pkg.sv
  - wb_ctrl_fsm.sv
  - div_iter.sv
  - wb_select.sv
  - exc_commit.sv
  - wb_stage.sv
  - target: test
    files:
      - wb_stage_chk.sv
      - tb_wb_stage.sv

/* div_iter.sv */
`timescale 1ns/10ps
`default_nettype none

module div_iter #(
    parameter int DIV_WIDTH = 32
) (
    input  logic                       clk,
    input  logic                       aresetn,
    input  logic                       start,
    input  logic                       lane,
    input  logic [DIV_WIDTH-1:0]       dividend,
    input  logic [DIV_WIDTH-1:0]       divisor,
    output logic [1:0][DIV_WIDTH-1:0]  quotient,
    output logic [1:0][DIV_WIDTH-1:0]  remainder,
    output logic                       done
);

    localparam int CNT_W = $clog2(DIV_WIDTH + 1);

    logic                 busy;
    logic [CNT_W-1:0]     cnt;
    logic                 lane_r;
    logic [DIV_WIDTH-1:0] quo_sh;
    logic [DIV_WIDTH-1:0] part_rem;
    logic [DIV_WIDTH-1:0] dsr;
    logic [DIV_WIDTH:0]   trial;
    logic [DIV_WIDTH:0]   diff;
    logic [DIV_WIDTH-1:0] quo_nxt;
    logic [DIV_WIDTH-1:0] rem_nxt;

    // shift in next dividend bit and try the subtract
    assign trial = {part_rem, quo_sh[DIV_WIDTH-1]};
    assign diff  = trial - {1'b0, dsr};

    // borrow means restore
    assign quo_nxt = {quo_sh[DIV_WIDTH-2:0], !diff[DIV_WIDTH]};
    assign rem_nxt = diff[DIV_WIDTH] ? trial[DIV_WIDTH-1:0] : diff[DIV_WIDTH-1:0];

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= busy && cnt == CNT_W'(1);
            if (start) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(DIV_WIDTH);
            end else if (busy) begin
                busy <= cnt != CNT_W'(1);
                cnt  <= cnt - 1'b1;
            end
        end
    end

    // zero divisor gives all ones and the dividend as remainder
    always_ff @(posedge clk) begin
        if (start) begin
            quo_sh   <= dividend;
            part_rem <= '0;
            dsr      <= divisor;
            lane_r   <= lane;
        end else if (busy) begin
            quo_sh   <= quo_nxt;
            part_rem <= rem_nxt;
            if (cnt == CNT_W'(1)) begin
                // one result pair per lane so a double divide keeps both
                quotient[lane_r]  <= quo_nxt;
                remainder[lane_r] <= rem_nxt;
            end
        end
    end

endmodule

`default_nettype wire

/* exc_commit.sv */
`timescale 1ns/10ps
`default_nettype none

module exc_commit import wb_pkg::*; (
    input  logic        clk,
    input  logic        aresetn,
    input  logic        take,
    input  exc_in_t     exc_in,
    input  logic        interrupt,
    input  logic [31:0] eentry,
    input  logic [31:0] tlbrentry,
    output exc_wr_t     exc_wr,
    output logic        kill
);

    logic is_tlbr;
    logic set_vppn;
    logic set_badv;
    logic hit;
    logic exc_take;

    assign is_tlbr  = exc_in.ecode == ecode_tlbr;
    // page faults and tlb refill carry a faulting va
    assign set_vppn = exc_in.ecode inside {ecode_pil, ecode_pis, ecode_pif, ecode_pme,
                                           ecode_ppi, ecode_tlbr};
    assign set_badv = set_vppn || exc_in.ecode inside {ecode_adef, ecode_ale};

    // a bundle taken during the flush cycle is wrong-path and dropped
    assign hit      = !exc_wr.flush && (exc_in.flag || interrupt);
    assign exc_take = take && !exc_wr.flush && exc_in.flag;
    assign kill     = exc_wr.flush || exc_in.flag || interrupt;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            exc_wr <= '0;
        end else begin
            exc_wr.flush    <= take && hit;
            exc_wr.wen_era  <= take && hit;
            exc_wr.tlb_exc  <= exc_take && is_tlbr;
            exc_wr.wen_badv <= exc_take && set_badv;
            exc_wr.wen_vppn <= exc_take && set_vppn;
            if (take) begin
                exc_wr.ecode       <= exc_in.ecode;
                exc_wr.badv        <= exc_in.badv;
                exc_wr.era         <= exc_in.era;
                exc_wr.vppn        <= exc_in.badv[18:0];
                exc_wr.redirect_pc <= (exc_in.flag && is_tlbr) ? tlbrentry : eentry;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_wb_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_wb_stage import wb_pkg::*; ();

    localparam int DIV_WIDTH    = 32;
    localparam int MAX_DELAY    = 8;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_ENT      = 32;
    localparam logic [31:0] DIV_MASK = 32'hffff_ffff >> (32 - DIV_WIDTH);
    localparam logic [3:0]  C_REM    = 4'b0001;
    localparam logic [3:0]  C_STORE  = 4'b0100;

    logic        clk;
    logic        aresetn;
    issue_t      issue0;
    issue_t      issue1;
    exc_in_t     exc_in;
    logic        interrupt;
    logic [31:0] csr_rdata;
    logic        csr_ready;
    logic [31:0] dcache_data;
    logic        dcache_ready;
    logic [31:0] eentry;
    logic [31:0] tlbrentry;
    logic        allowin;
    wb_port_t    wb0;
    wb_port_t    wb1;
    wb_port_t    wb2;
    exc_wr_t     exc_wr;

    // stimulus table with one row per bundle
    issue_t      tbl_i0    [MAX_ENT];
    issue_t      tbl_i1    [MAX_ENT];
    exc_in_t     tbl_exc   [MAX_ENT];
    logic        tbl_irq   [MAX_ENT];
    int          tbl_delay [MAX_ENT];
    logic [31:0] tbl_csr   [MAX_ENT];
    logic [31:0] tbl_dc    [MAX_ENT];
    int          n_ent;
    int          cycles;
    int          limit;
    int unsigned seed_dummy;

    wb_stage #(.DIV_WIDTH(DIV_WIDTH)) u_wb_stage (
        .clk          (clk),
        .aresetn      (aresetn),
        .issue0       (issue0),
        .issue1       (issue1),
        .exc_in       (exc_in),
        .interrupt    (interrupt),
        .csr_rdata    (csr_rdata),
        .csr_ready    (csr_ready),
        .dcache_data  (dcache_data),
        .dcache_ready (dcache_ready),
        .eentry       (eentry),
        .tlbrentry    (tlbrentry),
        .allowin      (allowin),
        .wb0          (wb0),
        .wb1          (wb1),
        .wb2          (wb2),
        .exc_wr       (exc_wr)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (u_wb_stage.u_chk.err_cnt != 0) begin
            $display("bound assertion failed before time %0t", $time);
            $display("CHECKS FAILED");
            $fatal(1, "assertion checker reported failures");
        end else if (cycles > limit) begin
            $display("timeout: allowin did not return within %0d cycles", limit);
            $display("CHECKS FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic issue_t mk(unit_e kind, logic [3:0] cond, logic zero_div);
        issue_t t;
        t.valid  = 1'b1;
        t.pc     = $urandom & 32'hffff_fffc;
        t.rd     = 5'($urandom);
        t.kind   = kind;
        t.cond   = cond;
        t.result = $urandom;
        t.src_a  = $urandom;
        // spread divisor sizes so quotients are not all tiny
        t.src_b  = zero_div ? 32'd0 : ($urandom >> ($urandom % 30));
        return t;
    endfunction

    // unsigned divide where a zero divisor gives all ones and the dividend back
    function automatic logic [31:0] ref_div(issue_t t, logic want_rem);
        logic [31:0] a;
        logic [31:0] b;
        a = t.src_a & DIV_MASK;
        b = t.src_b & DIV_MASK;
        if (b == 0) begin
            return want_rem ? a : DIV_MASK;
        end
        return want_rem ? a % b : a / b;
    endfunction

    function automatic wb_port_t expect_lane(issue_t t, logic [31:0] csr, logic killed);
        wb_port_t p;
        p.rd = t.rd;
        p.we = t.valid && !killed;
        case (t.kind)
            unit_alu:  p.data = t.result;
            unit_link: p.data = t.result + 32'd4;
            unit_div:  p.data = ref_div(t, t.cond.div_cond.rem);
            unit_csr:  p.data = csr;
            default: begin
                p.we   = 1'b0;
                p.data = '0;
            end
        endcase
        return p;
    endfunction

    // no divide, csr read or load means the bundle is taken at once
    function automatic logic takes_at_once(issue_t a, issue_t b);
        logic slow0;
        logic slow1;
        slow0 = a.valid && (a.kind == unit_div || a.kind == unit_csr
                || (a.kind == unit_load && !a.cond.mem_cond.store));
        slow1 = b.valid && b.kind == unit_div;
        return !slow0 && !slow1;
    endfunction

    // page faults and tlb refill record the faulting page
    function automatic logic carries_vppn(logic [6:0] code);
        return code == ecode_pil || code == ecode_pis || code == ecode_pif
            || code == ecode_pme || code == ecode_ppi || code == ecode_tlbr;
    endfunction

    function automatic logic carries_badv(logic [6:0] code);
        return carries_vppn(code) || code == ecode_adef || code == ecode_ale;
    endfunction

    task automatic add_entry(issue_t a, issue_t b, logic flag, logic [6:0] code, logic irq);
        exc_in_t e;
        e.flag           = flag;
        e.ecode          = code;
        e.badv           = $urandom;
        e.era            = $urandom & 32'hffff_fffc;
        tbl_i0[n_ent]    = a;
        tbl_i1[n_ent]    = b;
        tbl_exc[n_ent]   = e;
        tbl_irq[n_ent]   = irq;
        tbl_delay[n_ent] = $urandom % MAX_DELAY;
        tbl_csr[n_ent]   = $urandom;
        tbl_dc[n_ent]    = $urandom;
        n_ent            = n_ent + 1;
    endtask

    task automatic fill_table();
        n_ent = 0;
        add_entry(mk(unit_alu, 4'h0, 0), mk(unit_alu, 4'h0, 0), 0, 7'h0, 0);
        add_entry(mk(unit_link, 4'h0, 0), mk(unit_alu, 4'h0, 0), 0, 7'h0, 0);
        add_entry(mk(unit_div, 4'h0, 0), mk(unit_link, 4'h0, 0), 0, 7'h0, 0);
        add_entry(mk(unit_alu, 4'h0, 0), mk(unit_div, C_REM, 0), 0, 7'h0, 0);
        add_entry(mk(unit_div, 4'h0, 0), mk(unit_div, C_REM, 0), 0, 7'h0, 0);
        add_entry(mk(unit_div, C_REM, 1), mk(unit_div, 4'h0, 1), 0, 7'h0, 0);
        add_entry(mk(unit_csr, 4'h0, 0), mk(unit_alu, 4'h0, 0), 0, 7'h0, 0);
        add_entry(mk(unit_csr, 4'h0, 0), mk(unit_div, 4'h0, 0), 0, 7'h0, 0);
        add_entry(mk(unit_load, 4'h0, 0), mk(unit_alu, 4'h0, 0), 0, 7'h0, 0);
        add_entry(mk(unit_load, C_STORE, 0), mk(unit_link, 4'h0, 0), 0, 7'h0, 0);
        add_entry(mk(unit_load, 4'h0, 0), mk(unit_div, C_REM, 0), 0, 7'h0, 0);
        add_entry(mk(unit_none, 4'h0, 0), mk(unit_alu, 4'h0, 0), 0, 7'h0, 0);
        add_entry('0, '0, 0, 7'h0, 0);
        add_entry(mk(unit_alu, 4'h0, 0), mk(unit_link, 4'h0, 0), 1, ecode_pil, 0);
        add_entry(mk(unit_link, 4'h0, 0), mk(unit_alu, 4'h0, 0), 1, ecode_pis, 0);
        add_entry(mk(unit_alu, 4'h0, 0), mk(unit_alu, 4'h0, 0), 1, ecode_pif, 0);
        add_entry(mk(unit_load, 4'h0, 0), mk(unit_alu, 4'h0, 0), 1, ecode_pme, 0);
        add_entry(mk(unit_alu, 4'h0, 0), mk(unit_link, 4'h0, 0), 1, ecode_ppi, 0);
        add_entry(mk(unit_link, 4'h0, 0), mk(unit_alu, 4'h0, 0), 1, ecode_adef, 0);
        add_entry(mk(unit_load, 4'h0, 0), mk(unit_link, 4'h0, 0), 1, ecode_ale, 0);
        add_entry(mk(unit_alu, 4'h0, 0), mk(unit_alu, 4'h0, 0), 1, ecode_tlbr, 0);
        add_entry(mk(unit_div, 4'h0, 0), mk(unit_alu, 4'h0, 0), 1, ecode_sys, 0);
        add_entry(mk(unit_alu, 4'h0, 0), mk(unit_link, 4'h0, 0), 0, 7'h0, 1);
        limit = n_ent * (DIV_WIDTH * 2 + MAX_DELAY + 4) + RESET_CYCLES + 4;
    endtask

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("error: time %0t %s got %h expected %h", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_quiet();
        check_val("wb0.we", wb0.we, 1'b0);
        check_val("wb1.we", wb1.we, 1'b0);
        check_val("wb2.we", wb2.we, 1'b0);
        check_val("exc_wr.flush", exc_wr.flush, 1'b0);
        check_val("exc_wr.wen_era", exc_wr.wen_era, 1'b0);
        check_val("exc_wr.wen_badv", exc_wr.wen_badv, 1'b0);
        check_val("exc_wr.wen_vppn", exc_wr.wen_vppn, 1'b0);
    endtask

    task automatic check_entry(int idx);
        issue_t   a;
        exc_in_t  e;
        logic     killed;
        wb_port_t x0;
        wb_port_t x1;
        logic     x2_we;
        a      = tbl_i0[idx];
        e      = tbl_exc[idx];
        killed = e.flag || tbl_irq[idx];
        x0     = expect_lane(a, tbl_csr[idx], killed);
        x1     = expect_lane(tbl_i1[idx], tbl_csr[idx], killed);
        x2_we  = a.valid && a.kind == unit_load && !a.cond.mem_cond.store && !killed;
        check_val("wb0.we", wb0.we, x0.we);
        check_val("wb1.we", wb1.we, x1.we);
        check_val("wb2.we", wb2.we, x2_we);
        if (x0.we) begin
            check_val("wb0.rd", wb0.rd, x0.rd);
            check_val("wb0.data", wb0.data, x0.data);
        end
        if (x1.we) begin
            check_val("wb1.rd", wb1.rd, x1.rd);
            check_val("wb1.data", wb1.data, x1.data);
        end
        if (x2_we) begin
            check_val("wb2.rd", wb2.rd, a.rd);
            check_val("wb2.data", wb2.data, tbl_dc[idx]);
        end
        check_val("exc_wr.flush", exc_wr.flush, killed);
        check_val("exc_wr.wen_era", exc_wr.wen_era, killed);
        check_val("exc_wr.wen_badv", exc_wr.wen_badv, e.flag && carries_badv(e.ecode));
        check_val("exc_wr.wen_vppn", exc_wr.wen_vppn, e.flag && carries_vppn(e.ecode));
        check_val("exc_wr.tlb_exc", exc_wr.tlb_exc, e.flag && e.ecode == ecode_tlbr);
        if (killed) begin
            check_val("exc_wr.ecode", exc_wr.ecode, e.ecode);
            check_val("exc_wr.era", exc_wr.era, e.era);
            check_val("exc_wr.badv", exc_wr.badv, e.badv);
            check_val("exc_wr.vppn", exc_wr.vppn, e.badv[18:0]);
            check_val("exc_wr.redirect_pc", exc_wr.redirect_pc,
                      (e.flag && e.ecode == ecode_tlbr) ? tlbrentry : eentry);
        end
    endtask

    task automatic run_entry(int idx);
        int   waited;
        logic taken;
        logic flushed;
        @(posedge clk);
        issue0       <= tbl_i0[idx];
        issue1       <= tbl_i1[idx];
        exc_in       <= tbl_exc[idx];
        interrupt    <= tbl_irq[idx];
        csr_rdata    <= tbl_csr[idx];
        dcache_data  <= tbl_dc[idx];
        csr_ready    <= tbl_delay[idx] == 0;
        dcache_ready <= tbl_delay[idx] == 0;
        waited  = 0;
        taken   = 1'b0;
        flushed = tbl_exc[idx].flag || tbl_irq[idx];
        while (!taken) begin
            @(negedge clk);
            taken = allowin;
            @(posedge clk);
            if (!taken) begin
                waited = waited + 1;
                if (waited >= tbl_delay[idx]) begin
                    csr_ready    <= 1'b1;
                    dcache_ready <= 1'b1;
                end
            end
        end
        if (takes_at_once(tbl_i0[idx], tbl_i1[idx])) begin
            check_val("allowin wait cycles", waited, 0);
        end
        // wrong-path bundle in the flush cycle, sometimes faulting itself
        issue0       <= flushed ? mk(unit_alu, 4'h0, 1'b0) : '0;
        issue1       <= flushed ? mk(unit_link, 4'h0, 1'b0) : '0;
        exc_in       <= (flushed && idx[0]) ? tbl_exc[idx] : '0;
        interrupt    <= flushed && idx[0] && tbl_irq[idx];
        csr_ready    <= 1'b0;
        dcache_ready <= 1'b0;
        @(negedge clk);
        check_entry(idx);
    endtask

    initial begin
        seed_dummy   = $urandom(32'hda4e283c);
        clk          = 1'b0;
        aresetn      = 1'b0;
        issue0       = '0;
        issue1       = '0;
        exc_in       = '0;
        interrupt    = 1'b0;
        csr_rdata    = '0;
        csr_ready    = 1'b0;
        dcache_data  = '0;
        dcache_ready = 1'b0;
        eentry       = $urandom & 32'hffff_ffc0;
        tlbrentry    = $urandom & 32'hffff_ffc0;
        cycles       = 0;
        fill_table();
        repeat (RESET_CYCLES / 2) @(posedge clk);
        @(negedge clk);
        check_quiet();
        repeat (RESET_CYCLES / 2) @(posedge clk);
        aresetn <= 1'b1;
        @(negedge clk);
        check_quiet();
        for (int i = 0; i < n_ent; i++) begin
            run_entry(i);
        end
        repeat (2) @(negedge clk);
        if (u_wb_stage.u_chk.err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("bound assertions failed %0d times", u_wb_stage.u_chk.err_cnt);
            $display("CHECKS FAILED");
            $fatal(1, "assertion checker reported failures");
        end
    end

endmodule

`default_nettype wire

/* wb_ctrl_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_ctrl_fsm import wb_pkg::*; (
    input  logic   clk,
    input  logic   aresetn,
    input  issue_t issue0,
    input  issue_t issue1,
    input  logic   div_done,
    input  logic   csr_ready,
    input  logic   dcache_ready,
    output logic   allowin,
    output logic   div_start,
    output logic   div_op_sel
);

    typedef enum logic [1:0] {
        idle      = 2'd0,
        div_wait  = 2'd1,
        csr_wait  = 2'd2,
        load_wait = 2'd3
    } state_e;

    state_e     state;
    state_e     state_nxt;
    logic [1:0] div_cnt;
    logic [1:0] div_cnt_nxt;
    logic       div0;
    logic       div1;
    logic       csr0;
    logic       load0;

    assign div0  = issue0.valid && issue0.kind == unit_div;
    assign div1  = issue1.valid && issue1.kind == unit_div;
    assign csr0  = issue0.valid && issue0.kind == unit_csr;
    assign load0 = issue0.valid && issue0.kind == unit_load && !issue0.cond.mem_cond.store;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            state   <= idle;
            div_cnt <= 2'd0;
        end else begin
            state   <= state_nxt;
            div_cnt <= div_cnt_nxt;
        end
    end

    always_comb begin
        state_nxt   = state;
        div_cnt_nxt = div_cnt;
        allowin     = 1'b0;
        div_start   = 1'b0;
        div_op_sel  = 1'b0;
        case (state)
            idle: begin
                if (div0 || div1) begin
                    // lane 0 first and lane 1 second
                    div_start   = 1'b1;
                    div_op_sel  = !div0;
                    div_cnt_nxt = {1'b0, div0} + {1'b0, div1};
                    state_nxt   = div_wait;
                end else if (csr0) begin
                    allowin = csr_ready;
                    if (!csr_ready) begin
                        state_nxt = csr_wait;
                    end
                end else if (load0) begin
                    allowin = dcache_ready;
                    if (!dcache_ready) begin
                        state_nxt = load_wait;
                    end
                end else begin
                    allowin = 1'b1;
                end
            end
            div_wait: begin
                if (div_done) begin
                    div_cnt_nxt = div_cnt - 2'd1;
                    if (div_cnt == 2'd2) begin
                        div_start  = 1'b1;
                        div_op_sel = 1'b1;
                    end else if (csr0) begin
                        // csr read paired with a lane 1 divide
                        allowin   = csr_ready;
                        state_nxt = csr_ready ? idle : csr_wait;
                    end else if (load0) begin
                        allowin   = dcache_ready;
                        state_nxt = dcache_ready ? idle : load_wait;
                    end else begin
                        allowin   = 1'b1;
                        state_nxt = idle;
                    end
                end
            end
            csr_wait: begin
                allowin = csr_ready;
                if (csr_ready) begin
                    state_nxt = idle;
                end
            end
            default: begin
                allowin = dcache_ready;
                if (dcache_ready) begin
                    state_nxt = idle;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

/* wb_pkg.sv */
`default_nettype none

package wb_pkg;

    // work carried by one lane
    typedef enum logic [2:0] {
        unit_none = 3'd0,
        unit_alu  = 3'd1,
        unit_link = 3'd2,
        unit_div  = 3'd3,
        unit_csr  = 3'd4,
        unit_load = 3'd5
    } unit_e;

    // cond field as seen by the divider
    typedef struct packed {
        logic [2:0] rsvd;
        logic       rem;
    } div_cond_t;

    // cond field as seen by the memory pipe
    typedef struct packed {
        logic       rsvd_hi;
        logic       store;
        logic [1:0] rsvd_lo;
    } mem_cond_t;

    typedef union packed {
        div_cond_t div_cond;
        mem_cond_t mem_cond;
    } cond_u;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        unit_e       kind;
        cond_u       cond;
        logic [31:0] result;
        // divide operands replace result for a divide
        logic [31:0] src_a;
        logic [31:0] src_b;
    } issue_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_port_t;

    typedef struct packed {
        logic        flag;
        logic [6:0]  ecode;
        logic [31:0] badv;
        logic [31:0] era;
    } exc_in_t;

    typedef struct packed {
        logic        flush;
        logic        tlb_exc;
        logic [6:0]  ecode;
        logic [31:0] badv;
        logic        wen_badv;
        logic [31:0] era;
        logic        wen_era;
        logic [18:0] vppn;
        logic        wen_vppn;
        logic [31:0] redirect_pc;
    } exc_wr_t;

    localparam logic [6:0] ecode_pil  = 7'h01;
    localparam logic [6:0] ecode_pis  = 7'h02;
    localparam logic [6:0] ecode_pif  = 7'h03;
    localparam logic [6:0] ecode_pme  = 7'h04;
    localparam logic [6:0] ecode_ppi  = 7'h07;
    localparam logic [6:0] ecode_adef = 7'h08;
    localparam logic [6:0] ecode_ale  = 7'h09;
    localparam logic [6:0] ecode_sys  = 7'h0b;
    localparam logic [6:0] ecode_tlbr = 7'h3f;

    // return address of a link op
    localparam logic [31:0] link_offset = 32'd4;

endpackage

`default_nettype wire

/* wb_select.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_select import wb_pkg::*; #(
    parameter int DIV_WIDTH = 32
) (
    input  logic                 clk,
    input  logic                 aresetn,
    input  logic                 take,
    input  logic                 kill,
    input  issue_t               issue0,
    input  issue_t               issue1,
    input  logic [DIV_WIDTH-1:0] q0,
    input  logic [DIV_WIDTH-1:0] r0,
    input  logic [DIV_WIDTH-1:0] q1,
    input  logic [DIV_WIDTH-1:0] r1,
    input  logic [31:0]          csr_rdata,
    input  logic [31:0]          dcache_data,
    output wb_port_t             wb0,
    output wb_port_t             wb1,
    output wb_port_t             wb2
);

    logic [31:0] q0_x;
    logic [31:0] r0_x;
    logic [31:0] q1_x;
    logic [31:0] r1_x;
    wb_port_t    lane0;
    wb_port_t    lane1;
    wb_port_t    load_port;

    assign q0_x = 32'(q0);
    assign r0_x = 32'(r0);
    assign q1_x = 32'(q1);
    assign r1_x = 32'(r1);

    function automatic wb_port_t lane_port(
        issue_t      is,
        logic [31:0] quo,
        logic [31:0] rem,
        logic [31:0] csr_data
    );
        wb_port_t p;
        p.we = is.valid;
        p.rd = is.rd;
        case (is.kind)
            unit_alu:  p.data = is.result;
            unit_link: p.data = is.result + link_offset;
            unit_div:  p.data = is.cond.div_cond.rem ? rem : quo;
            unit_csr:  p.data = csr_data;
            default: begin
                // loads use port 2 and stores or none write nothing
                p.we   = 1'b0;
                p.data = is.result;
            end
        endcase
        return p;
    endfunction

    assign lane0 = lane_port(issue0, q0_x, r0_x, csr_rdata);
    assign lane1 = lane_port(issue1, q1_x, r1_x, csr_rdata);

    assign load_port.we   = issue0.valid && issue0.kind == unit_load
                            && !issue0.cond.mem_cond.store;
    assign load_port.rd   = issue0.rd;
    assign load_port.data = dcache_data;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            wb0 <= '0;
            wb1 <= '0;
            wb2 <= '0;
        end else begin
            wb0.we <= take && !kill && lane0.we;
            wb1.we <= take && !kill && lane1.we;
            wb2.we <= take && !kill && load_port.we;
            if (take) begin
                wb0.rd   <= lane0.rd;
                wb0.data <= lane0.data;
                wb1.rd   <= lane1.rd;
                wb1.data <= lane1.data;
                wb2.rd   <= load_port.rd;
                wb2.data <= load_port.data;
            end
        end
    end

endmodule

`default_nettype wire

/* wb_stage.f */
wb_pkg.sv
wb_ctrl_fsm.sv
div_iter.sv
wb_select.sv
exc_commit.sv
wb_stage.sv
wb_stage_chk.sv
tb_wb_stage.sv

/* wb_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_stage import wb_pkg::*; #(
    parameter int DIV_WIDTH = 32
) (
    input  logic        clk,
    input  logic        aresetn,
    input  issue_t      issue0,
    input  issue_t      issue1,
    input  exc_in_t     exc_in,
    input  logic        interrupt,
    input  logic [31:0] csr_rdata,
    input  logic        csr_ready,
    input  logic [31:0] dcache_data,
    input  logic        dcache_ready,
    input  logic [31:0] eentry,
    input  logic [31:0] tlbrentry,
    output logic        allowin,
    output wb_port_t    wb0,
    output wb_port_t    wb1,
    output wb_port_t    wb2,
    output exc_wr_t     exc_wr
);

    logic                      div_start;
    logic                      div_op_sel;
    logic                      div_done;
    logic                      kill;
    logic [DIV_WIDTH-1:0]      div_a;
    logic [DIV_WIDTH-1:0]      div_b;
    logic [1:0][DIV_WIDTH-1:0] quotient;
    logic [1:0][DIV_WIDTH-1:0] remainder;

    // operand bits above DIV_WIDTH are not used
    assign div_a = div_op_sel ? issue1.src_a[DIV_WIDTH-1:0] : issue0.src_a[DIV_WIDTH-1:0];
    assign div_b = div_op_sel ? issue1.src_b[DIV_WIDTH-1:0] : issue0.src_b[DIV_WIDTH-1:0];

    wb_ctrl_fsm u_ctrl (
        .clk          (clk),
        .aresetn      (aresetn),
        .issue0       (issue0),
        .issue1       (issue1),
        .div_done     (div_done),
        .csr_ready    (csr_ready),
        .dcache_ready (dcache_ready),
        .allowin      (allowin),
        .div_start    (div_start),
        .div_op_sel   (div_op_sel)
    );

    div_iter #(.DIV_WIDTH(DIV_WIDTH)) u_div (
        .clk       (clk),
        .aresetn   (aresetn),
        .start     (div_start),
        .lane      (div_op_sel),
        .dividend  (div_a),
        .divisor   (div_b),
        .quotient  (quotient),
        .remainder (remainder),
        .done      (div_done)
    );

    wb_select #(.DIV_WIDTH(DIV_WIDTH)) u_select (
        .clk         (clk),
        .aresetn     (aresetn),
        .take        (allowin),
        .kill        (kill),
        .issue0      (issue0),
        .issue1      (issue1),
        .q0          (quotient[0]),
        .r0          (remainder[0]),
        .q1          (quotient[1]),
        .r1          (remainder[1]),
        .csr_rdata   (csr_rdata),
        .dcache_data (dcache_data),
        .wb0         (wb0),
        .wb1         (wb1),
        .wb2         (wb2)
    );

    exc_commit u_exc (
        .clk       (clk),
        .aresetn   (aresetn),
        .take      (allowin),
        .exc_in    (exc_in),
        .interrupt (interrupt),
        .eentry    (eentry),
        .tlbrentry (tlbrentry),
        .exc_wr    (exc_wr),
        .kill      (kill)
    );

endmodule

`default_nettype wire

/* wb_stage_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_stage_chk import wb_pkg::*; (
    input  logic     clk,
    input  logic     aresetn,
    input  logic     allowin,
    input  logic     div_done,
    input  logic     div_wait_st,
    input  wb_port_t wb0,
    input  wb_port_t wb1,
    input  wb_port_t wb2,
    input  exc_wr_t  exc_wr
);

    int unsigned err_cnt = 0;
    logic        any_we;

    assign any_we = wb0.we || wb1.we || wb2.we;

    flush_one_cycle: assert property (@(posedge clk) disable iff (!aresetn)
        exc_wr.flush |=> !exc_wr.flush)
    else begin
        $error("flush held for more than one cycle");
        err_cnt = err_cnt + 1;
    end

    // wrong-path bundle behind a flush must not write
    no_we_after_flush: assert property (@(posedge clk) disable iff (!aresetn)
        exc_wr.flush |=> !any_we)
    else begin
        $error("register write in the cycle after flush");
        err_cnt = err_cnt + 1;
    end

    no_we_in_reset: assert property (@(posedge clk) !aresetn |-> !any_we)
    else begin
        $error("register write while reset is asserted");
        err_cnt = err_cnt + 1;
    end

    div_holds_allowin: assert property (@(posedge clk) disable iff (!aresetn)
        div_wait_st && !div_done |-> !allowin)
    else begin
        $error("allowin raised before the divider finished");
        err_cnt = err_cnt + 1;
    end

endmodule

bind wb_stage wb_stage_chk u_chk (
    .clk         (clk),
    .aresetn     (aresetn),
    .allowin     (allowin),
    .div_done    (div_done),
    .div_wait_st (u_ctrl.state == 2'd1),
    .wb0         (wb0),
    .wb1         (wb1),
    .wb2         (wb2),
    .exc_wr      (exc_wr)
);

`default_nettype wire
